/* hw/video_defs.svh */
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Video timing
////////////////////////////////////////////////////////////////////////////

// Counter and timing width, covers the longest line and frame
`define VID_CNT_W 11

////////////////////////////////////////////////////////////////////////////
// Mode switches
////////////////////////////////////////////////////////////////////////////

`define SW_W 4          // Switch vector width
`define SYNC_STAGES 2   // Metastability flops
`define DEBOUNCE_LEN 64 // Cycles the vector must hold still

////////////////////////////////////////////////////////////////////////////
// Clock synthesizer programmer
////////////////////////////////////////////////////////////////////////////

`define CLKGEN_VAL_W 8  // M or D value bits
`define CLKGEN_CMD_W 2  // Command bits ahead of the value
`define CLKGEN_GAP 2    // Idle cycles after each frame

`endif

/* hw/video_mode_pkg.sv */
`include "video_defs.svh"

package video_mode_pkg;

	typedef logic [`VID_CNT_W-1:0] vid_cnt_t;

	// Switch codes as read from the board
	typedef enum logic [3:0] {
		MODE_VGA    = 4'b0000,
		MODE_SVGA   = 4'b0001,
		MODE_720P   = 4'b0010,
		MODE_XGA    = 4'b0011,
		MODE_SXGA   = 4'b1000,
		MODE_CAMERA = 4'b1001
	} mode_t;

	// Terminal counts, all relative to count 0 at first active pixel
	typedef struct packed {
		logic     neg_pol;      // 1 means sync pulses low
		vid_cnt_t h_active_end; // Last active pixel
		vid_cnt_t h_sync_start;
		vid_cnt_t h_sync_end;
		vid_cnt_t h_line_end;   // Last count of the line
		vid_cnt_t v_active_end; // Last active line
		vid_cnt_t v_sync_start;
		vid_cnt_t v_sync_end;
		vid_cnt_t v_frame_end;  // Last line of the frame
	} mode_timing_t;

	// Builds the cumulative counts from active, porch and sync sizes
	function automatic mode_timing_t make_timing(input logic neg,
		input int ha, hfp, hs, hbp, input int va, vfp, vs, vbp);
		mode_timing_t t;
		t.neg_pol      = neg;
		t.h_active_end = vid_cnt_t'(ha - 1);
		t.h_sync_start = vid_cnt_t'(ha - 1 + hfp);
		t.h_sync_end   = vid_cnt_t'(ha - 1 + hfp + hs);
		t.h_line_end   = vid_cnt_t'(ha - 1 + hfp + hs + hbp);
		t.v_active_end = vid_cnt_t'(va - 1);
		t.v_sync_start = vid_cnt_t'(va - 1 + vfp);
		t.v_sync_end   = vid_cnt_t'(va - 1 + vfp + vs);
		t.v_frame_end  = vid_cnt_t'(va - 1 + vfp + vs + vbp);
		return t;
	endfunction

	// Per mode table
	function automatic mode_timing_t mode_timing(input mode_t mode);
		mode_timing_t t;
		case (mode)
			MODE_VGA:    t = make_timing(1'b1,  640,  16,  96,  48,  480, 11, 2, 31);
			MODE_SVGA:   t = make_timing(1'b0,  800,  40, 128,  88,  600,  1, 4, 23);
			MODE_XGA:    t = make_timing(1'b1, 1024,  24, 136, 160,  768,  3, 6, 29);
			MODE_SXGA:   t = make_timing(1'b0, 1280,  48, 112, 248, 1024,  1, 3, 38);
			MODE_CAMERA: t = make_timing(1'b0, 1280, 110,  39, 220,  720,  4, 4, 22);
			default:     t = make_timing(1'b0, 1280, 110,  40, 220,  720,  5, 5, 20); // 720p
		endcase
		return t;
	endfunction

endpackage

/* hw/clkgen_pkg.sv */
`include "video_defs.svh"

package clkgen_pkg;

	// Command field, shifted out ahead of the value
	typedef enum logic [`CLKGEN_CMD_W-1:0] {
		LOAD_D = 2'b01,
		LOAD_M = 2'b11
	} clkgen_cmd_t;

	// Both values are stored minus one
	typedef struct packed {
		logic [`CLKGEN_VAL_W-1:0] m;
		logic [`CLKGEN_VAL_W-1:0] d;
	} clkgen_md_t;

	function automatic clkgen_md_t md_pair(input int mult, input int div);
		clkgen_md_t md;
		md.m = (`CLKGEN_VAL_W)'(mult - 1);
		md.d = (`CLKGEN_VAL_W)'(div - 1);
		return md;
	endfunction

	// 50 MHz in, pixel clock out
	function automatic clkgen_md_t clkgen_values(input logic [`SW_W-1:0] code);
		clkgen_md_t md;
		case (code)
			4'b0000: md = md_pair(2, 4);      // VGA 25 MHz
			4'b0001: md = md_pair(4, 5);      // SVGA 40 MHz
			4'b0011: md = md_pair(13, 10);    // XGA 65 MHz
			4'b1000: md = md_pair(54, 25);    // SXGA 108 MHz
			4'b1001: md = md_pair(135, 91);   // Camera
			default: md = md_pair(248, 167);  // 720p 74.25 MHz
		endcase
		return md;
	endfunction

endpackage

/* hw/switch_sync.sv */
`timescale 1ns/1ps
`include "video_defs.svh"

module switch_sync (
	input  logic             clk50m_bufg,
	input  logic             RSTBTN,
	input  logic [`SW_W-1:0] sw,        // Raw board switches
	output logic [`SW_W-1:0] sw_stable, // Debounced copy
	output logic             sw_valid   // First stable value seen
);

	localparam int CNT_W = $clog2(`DEBOUNCE_LEN + 1);

	logic [`SYNC_STAGES-1:0][`SW_W-1:0] sync_q;
	logic [`SW_W-1:0]                   sync_val;
	logic [`SW_W-1:0]                   sync_last; // Value being timed
	logic [CNT_W-1:0]                   stab_cnt;

	assign sync_val = sync_q[`SYNC_STAGES-1];

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sync_q    <= '0;
			sync_last <= '0;
			stab_cnt  <= '0;
			sw_valid  <= 1'b0;
		end else begin
			sync_q <= {sync_q[`SYNC_STAGES-2:0], sw};
			if (sync_val != sync_last) begin // Any bit moved
				sync_last <= sync_val;
				stab_cnt  <= '0;
			end else if (stab_cnt != CNT_W'(`DEBOUNCE_LEN)) begin
				stab_cnt <= stab_cnt + 1'b1;
			end
			if (sync_val == sync_last && stab_cnt == CNT_W'(`DEBOUNCE_LEN - 1))
				sw_valid <= 1'b1;
		end
	end

	// Accept once per quiet period, count then parks at the limit
	always_ff @(posedge clk50m_bufg) begin
		if (sync_val == sync_last && stab_cnt == CNT_W'(`DEBOUNCE_LEN - 1))
			sw_stable <= sync_last;
	end

endmodule

/* hw/mode_ctrl.sv */
`timescale 1ns/1ps
`include "video_defs.svh"

module mode_ctrl (
	input  logic                  clk50m_bufg,
	input  logic                  RSTBTN,
	input  logic [`SW_W-1:0]      sw_stable,
	input  logic                  sw_valid,
	input  logic                  busy,      // Programmer running
	output video_mode_pkg::mode_t mode,      // Timing mode, unknown codes folded
	output logic [`SW_W-1:0]      mode_code, // Raw code for the clock table
	output logic                  restart,
	output logic                  go
);

	import video_mode_pkg::*;

	logic  have_mode; // A value was taken since reset
	logic  pending;   // Change waiting for the programmer
	logic  change;
	logic  prog_busy;
	mode_t next_mode;

	// New accepted value, or the first one after reset
	assign change = sw_valid && (!have_mode || sw_stable != mode_code);

	// Busy rises the cycle after go, so cover that cycle too
	assign prog_busy = busy | go;

	// Fold unlisted codes onto 720p
	always_comb begin
		case (sw_stable)
			MODE_VGA, MODE_SVGA, MODE_720P, MODE_XGA, MODE_SXGA, MODE_CAMERA:
				next_mode = mode_t'(sw_stable);
			default:
				next_mode = MODE_720P;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Mode register and pulse generation
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			have_mode <= 1'b0;
			pending   <= 1'b0;
			mode      <= MODE_VGA;
			mode_code <= '0;
			restart   <= 1'b0;
			go        <= 1'b0;
		end else begin
			restart <= 1'b0; // Single cycle pulses
			go      <= 1'b0;
			if (change) begin
				have_mode <= 1'b1;
				mode      <= next_mode;
				mode_code <= sw_stable;
				restart   <= 1'b1;    // Timing restarts at once
				go        <= !prog_busy;
				pending   <= prog_busy; // Else send when idle
			end else if (pending && !prog_busy) begin
				go      <= 1'b1;      // Latest mode_code goes out
				pending <= 1'b0;
			end
		end
	end

endmodule

/* hw/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
	input  logic                  clk50m_bufg,
	input  logic                  RSTBTN,
	input  logic                  restart,
	input  video_mode_pkg::mode_t mode,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  de
);

	import video_mode_pkg::*;

	mode_timing_t tm;
	vid_cnt_t     hcnt;
	vid_cnt_t     vcnt;
	logic         running;  // Set by the first restart
	logic         line_end;
	logic         hblnk;
	logic         vblnk;
	logic         hsync_raw;
	logic         vsync_raw;
	logic         active;
	logic         hsync_q;  // First output stage
	logic         vsync_q;
	logic         active_q;

	assign tm = mode_timing(mode);

	////////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////////

	assign line_end = (hcnt >= tm.h_line_end);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			running <= 1'b0;
			hcnt    <= '0;
			vcnt    <= '0;
		end else if (restart) begin
			running <= 1'b1;
			hcnt    <= '0;
			vcnt    <= '0;
		end else if (running) begin
			if (line_end) begin
				hcnt <= '0;
				// Vertical steps once per line
				if (vcnt >= tm.v_frame_end)
					vcnt <= '0;
				else
					vcnt <= vcnt + 1'b1;
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// Blanking past the active region
	assign hblnk = (hcnt > tm.h_active_end);
	assign vblnk = (vcnt > tm.v_active_end);

	// Sync window is (start, end]
	assign hsync_raw = (hcnt > tm.h_sync_start) && (hcnt <= tm.h_sync_end);
	assign vsync_raw = (vcnt > tm.v_sync_start) && (vcnt <= tm.v_sync_end);

	assign active = running && !hblnk && !vblnk;

	////////////////////////////////////////////////////////////////////////////
	// Output pipeline
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q  <= 1'b0;
			vsync_q  <= 1'b0;
			active_q <= 1'b0;
			hsync    <= 1'b0;
			vsync    <= 1'b0;
			de       <= 1'b0;
		end else begin
			// Polarity only once running, outputs stay low before that
			hsync_q  <= running && (hsync_raw ^ tm.neg_pol);
			vsync_q  <= running && (vsync_raw ^ tm.neg_pol);
			active_q <= active;
			hsync    <= hsync_q;
			vsync    <= vsync_q;
			de       <= active_q;
		end
	end

endmodule

/* hw/clkgen_prog.sv */
`timescale 1ns/1ps
`include "video_defs.svh"

module clkgen_prog (
	input  logic             clk50m_bufg,
	input  logic             RSTBTN,
	input  logic             go,        // Start pulse, only while idle
	input  logic [`SW_W-1:0] mode_code,
	output logic             busy,
	output logic             progen,    // Frame enable
	output logic             progdata   // Serial data, LSB first
);

	import clkgen_pkg::*;

	localparam int FRAME_LEN = `CLKGEN_CMD_W + `CLKGEN_VAL_W; // Command plus value
	localparam int BIT_W     = $clog2(FRAME_LEN);
	localparam int GAP_W     = $clog2(`CLKGEN_GAP + 1);

	typedef enum logic [1:0] {ST_IDLE, ST_ARM, ST_SEND, ST_GAP} state_t;

	state_t               state;
	clkgen_md_t           md_q;      // Values latched on go
	logic [FRAME_LEN-1:0] shreg;
	logic [BIT_W-1:0]     bit_cnt;   // Bits left in this frame
	logic [GAP_W-1:0]     gap_cnt;
	logic [1:0]           frame_idx; // 0 D, 1 M, 2 GO

	assign progdata = shreg[0];

	always_ff @(posedge clk50m_bufg) begin
		if (go && state == ST_IDLE)
			md_q <= clkgen_values(mode_code);
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state     <= ST_IDLE;
			busy      <= 1'b0;
			progen    <= 1'b0;
			shreg     <= '0;
			bit_cnt   <= '0;
			gap_cnt   <= '0;
			frame_idx <= '0;
		end else begin
			case (state)
				ST_IDLE: if (go) begin
					busy  <= 1'b1;
					state <= ST_ARM; // Values settle one cycle
				end
				ST_ARM: begin
					shreg     <= {md_q.d, LOAD_D};
					bit_cnt   <= BIT_W'(FRAME_LEN - 1);
					frame_idx <= 2'd0;
					progen    <= 1'b1;
					state     <= ST_SEND;
				end
				ST_SEND: if (bit_cnt == '0) begin
					progen  <= 1'b0;
					shreg   <= '0;     // Data low between frames
					gap_cnt <= GAP_W'(`CLKGEN_GAP - 1);
					state   <= ST_GAP;
				end else begin
					shreg   <= shreg >> 1;
					bit_cnt <= bit_cnt - 1'b1;
				end
				ST_GAP: if (gap_cnt != '0) begin
					gap_cnt <= gap_cnt - 1'b1;
				end else if (frame_idx == 2'd0) begin
					shreg     <= {md_q.m, LOAD_M};
					bit_cnt   <= BIT_W'(FRAME_LEN - 1);
					frame_idx <= 2'd1;
					progen    <= 1'b1;
					state     <= ST_SEND;
				end else if (frame_idx == 2'd1) begin
					shreg     <= FRAME_LEN'(1); // GO is a single high bit
					bit_cnt   <= '0;
					frame_idx <= 2'd2;
					progen    <= 1'b1;
					state     <= ST_SEND;
				end else begin
					busy  <= 1'b0;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* hw/hdmi_mode_gen.sv */
`timescale 1ns/1ps
`include "video_defs.svh"

module hdmi_mode_gen (
	input  logic             clk50m_bufg,
	input  logic             RSTBTN,
	input  logic [`SW_W-1:0] sw,
	output logic             hsync,
	output logic             vsync,
	output logic             de,
	output logic             progen,
	output logic             progdata,
	output logic             busy
);

	import video_mode_pkg::*;

	logic [`SW_W-1:0] sw_stable;
	logic             sw_valid;
	mode_t            mode;
	logic [`SW_W-1:0] mode_code;
	logic             restart;
	logic             go;

	////////////////////////////////////////////////////////////////////////////
	// Switch input and mode control
	////////////////////////////////////////////////////////////////////////////

	switch_sync i_switch_sync (
		.clk50m_bufg(clk50m_bufg), .RSTBTN(RSTBTN), .sw(sw),
		.sw_stable(sw_stable), .sw_valid(sw_valid)
	);

	mode_ctrl i_mode_ctrl (
		.clk50m_bufg(clk50m_bufg), .RSTBTN(RSTBTN),
		.sw_stable(sw_stable), .sw_valid(sw_valid), .busy(busy),
		.mode(mode), .mode_code(mode_code), .restart(restart), .go(go)
	);

	// Sync and DE for the DVI transmitter
	video_timing i_video_timing (
		.clk50m_bufg(clk50m_bufg), .RSTBTN(RSTBTN), .restart(restart), .mode(mode),
		.hsync(hsync), .vsync(vsync), .de(de)
	);

	// Serial port of the pixel clock synthesizer
	clkgen_prog i_clkgen_prog (
		.clk50m_bufg(clk50m_bufg), .RSTBTN(RSTBTN), .go(go), .mode_code(mode_code),
		.busy(busy), .progen(progen), .progdata(progdata)
	);

endmodule

/* tb/tb_hdmi_mode_gen.sv */
`timescale 1ns/1ps
`include "video_defs.svh"

module tb_hdmi_mode_gen;

	localparam int FRAME_LEN  = `CLKGEN_CMD_W + `CLKGEN_VAL_W; // Command plus value bits
	localparam int N_RAND     = 4;  // Random mode changes
	localparam int N_LINES    = 3;  // Lines per timing measurement
	localparam int START_MAX  = `DEBOUNCE_LEN + `SYNC_STAGES + 16; // Switch to first frame
	localparam int QUIET_CYC  = 2 * `DEBOUNCE_LEN;
	localparam int PROG_CYC   = 2 + 2 * (FRAME_LEN + `CLKGEN_GAP) + 1 + `CLKGEN_GAP + 1;
	localparam int MAX_LINE   = 1688;            // SXGA has the longest line
	localparam int MAX_FRAME  = 1066 * MAX_LINE; // and the longest frame
	localparam int VGA_FRAME  = 525 * 800;
	localparam int GLITCH_CYC = 4 * `DEBOUNCE_LEN;
	localparam int N_SETTINGS = N_RAND + 7;
	localparam int N_MEAS     = N_RAND + 4;
	localparam int WATCHDOG_CYC = 2 * (N_SETTINGS * (START_MAX + PROG_CYC + QUIET_CYC)
		+ N_MEAS * (MAX_FRAME + N_LINES * MAX_LINE) + 2 * VGA_FRAME + GLITCH_CYC + 8);

	logic             clk50m_bufg;
	logic             RSTBTN;
	logic [`SW_W-1:0] sw;
	logic             hsync;
	logic             vsync;
	logic             de;
	logic             progen;
	logic             progdata;
	logic             busy;

	logic [31:0]      rng_state;
	logic [`SW_W-1:0] cur_code; // Code the DUT runs now
	string            test_name;

	////////////////////////////////////////////////////////////////////////////
	// Reference model tables
	////////////////////////////////////////////////////////////////////////////

	// Index 0 VGA, 1 SVGA, 2 XGA, 3 720p, 4 SXGA, 5 CAMERA
	logic [`SW_W-1:0] listed_codes [6] = '{4'h0, 4'h1, 4'h3, 4'h2, 4'h8, 4'h9};
	int ref_ha   [6] = '{640, 800, 1024, 1280, 1280, 1280}; // Active pixels
	int ref_hfp  [6] = '{16, 40, 24, 110, 48, 110};
	int ref_hs   [6] = '{96, 128, 136, 40, 112, 39};
	int ref_hbp  [6] = '{48, 88, 160, 220, 248, 220};
	int ref_va   [6] = '{480, 600, 768, 720, 1024, 720};    // Active lines
	int ref_vs   [6] = '{2, 4, 6, 5, 3, 4};
	bit ref_neg  [6] = '{1, 0, 1, 0, 0, 0};                 // Sync pulses low
	int ref_mult [6] = '{2, 4, 13, 248, 54, 135};
	int ref_div  [6] = '{4, 5, 10, 167, 25, 91};

	hdmi_mode_gen i_dut (
		.clk50m_bufg(clk50m_bufg), .RSTBTN(RSTBTN), .sw(sw),
		.hsync(hsync), .vsync(vsync), .de(de),
		.progen(progen), .progdata(progdata), .busy(busy)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk50m_bufg);
		$display("timeout: test %s still running after %0d cycles", test_name, WATCHDOG_CYC);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int ref_index(input logic [`SW_W-1:0] code);
		for (int i = 0; i < 6; i++) begin
			if (listed_codes[i] == code)
				return i;
		end
		return 3; // Unlisted codes run as 720p
	endfunction

	function automatic logic is_listed(input logic [`SW_W-1:0] code);
		return code inside {4'h0, 4'h1, 4'h2, 4'h3, 4'h8, 4'h9};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and sampling
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_run();
		$display("sim failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_level(input string what, input logic exp_v, input logic act_v);
		assert (act_v === exp_v) else begin
			$display("error %s %s: expected %0b, actual %0b", test_name, what, exp_v, act_v);
			fail_run();
		end
	endtask

	task automatic check_value(input string what, input int exp_v, input int act_v);
		assert (act_v == exp_v) else begin
			$display("error %s %s: expected %0d, actual %0d", test_name, what, exp_v, act_v);
			fail_run();
		end
	endtask

	// Outputs are stable at the falling edge, where inputs change too
	task automatic next_sample();
		@(negedge clk50m_bufg);
	endtask

	task automatic check_all_low();
		check_level("de", 1'b0, de);
		check_level("progen", 1'b0, progen);
		check_level("busy", 1'b0, busy);
		check_level("hsync", 1'b0, hsync);
		check_level("vsync", 1'b0, vsync);
	endtask

	task automatic expect_quiet(input int n);
		repeat (n) begin
			check_level("busy while idle", 1'b0, busy);
			check_level("progen while idle", 1'b0, progen);
			next_sample();
		end
	endtask

	task automatic pick_code(input logic [`SW_W-1:0] avoid, input logic listed,
		output logic [`SW_W-1:0] code);
		do begin
			rng_state = xorshift32(rng_state);
			code = listed ? listed_codes[int'(rng_state[7:0]) % 6] : rng_state[3:0];
		end while (code == avoid || is_listed(code) != listed);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Programming sequence decode
	////////////////////////////////////////////////////////////////////////////

	// One frame, LSB first, then the idle gap
	task automatic read_frame(input string what, input int len,
		input logic [FRAME_LEN-1:0] exp_bits);
		logic [FRAME_LEN-1:0] got;
		got = '0;
		for (int i = 0; i < len; i++) begin
			check_level({what, " progen"}, 1'b1, progen);
			got[i] = progdata;
			next_sample();
		end
		check_value(what, int'(exp_bits), int'(got));
		repeat (`CLKGEN_GAP) begin
			check_level({what, " gap progen"}, 1'b0, progen);
			check_level({what, " gap busy"}, 1'b1, busy);
			next_sample();
		end
	endtask

	task automatic capture_prog(input logic [`SW_W-1:0] code, input int max_wait);
		int                   idx;
		int                   waited;
		logic [FRAME_LEN-1:0] exp_d;
		logic [FRAME_LEN-1:0] exp_m;
		idx   = ref_index(code);
		exp_d = {(`CLKGEN_VAL_W)'(ref_div[idx] - 1), 2'b01};  // LOAD_D
		exp_m = {(`CLKGEN_VAL_W)'(ref_mult[idx] - 1), 2'b11}; // LOAD_M
		waited = 0;
		while (progen !== 1'b1) begin
			waited++;
			assert (waited <= max_wait) else begin
				$display("%s: no programming sequence for code %h within %0d cycles",
					test_name, code, max_wait);
				fail_run();
			end
			next_sample();
		end
		check_level("busy at first frame", 1'b1, busy);
		read_frame("LOAD_D frame", FRAME_LEN, exp_d);
		read_frame("LOAD_M frame", FRAME_LEN, exp_m);
		read_frame("GO frame", 1, FRAME_LEN'(1)); // Single high bit
		check_level("busy after sequence", 1'b0, busy);
	endtask

	task automatic change_mode(input logic [`SW_W-1:0] code);
		sw = code;
		capture_prog(code, START_MAX);
		cur_code = code;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Video timing measurement
	////////////////////////////////////////////////////////////////////////////

	task automatic measure_line(input logic [`SW_W-1:0] code);
		int   idx;
		int   total;
		int   run;
		int   width;
		int   period;
		logic idle;
		idx   = ref_index(code);
		total = ref_ha[idx] + ref_hfp[idx] + ref_hs[idx] + ref_hbp[idx];
		idle  = ref_neg[idx];
		while (de === 1'b1) next_sample(); // Skip a partial run
		while (de !== 1'b1) next_sample();
		run = 0;
		while (de === 1'b1) begin
			check_level("hsync idle level", idle, hsync);
			check_level("vsync idle level", idle, vsync);
			run++;
			next_sample();
		end
		check_value("active pixels", ref_ha[idx], run);
		while (hsync === idle) next_sample(); // First pulse after the run
		repeat (N_LINES) begin
			width = 0;
			while (hsync !== idle) begin
				width++;
				next_sample();
			end
			check_value("hsync width", ref_hs[idx], width);
			period = width;
			while (hsync === idle) begin
				period++;
				next_sample();
			end
			check_value("line total", total, period);
		end
	endtask

	task automatic check_vga_frame();
		int   width;
		int   lines;
		logic idle;
		logic de_prev;
		idle = ref_neg[0];
		while (vsync !== idle) next_sample();
		while (vsync === idle) next_sample(); // Start of vsync pulse
		width = 0;
		while (vsync !== idle) begin
			width++;
			next_sample();
		end
		check_value("vsync width", ref_vs[0] * (ref_ha[0] + ref_hfp[0] + ref_hs[0] + ref_hbp[0]),
			width);
		lines   = 0;
		de_prev = de;
		while (vsync === idle) begin // One whole frame up to next pulse
			if (de === 1'b1 && de_prev !== 1'b1)
				lines++;
			de_prev = de;
			next_sample();
		end
		check_value("lines with de", ref_va[0], lines);
	endtask

	// Bursts shorter than the debounce window
	task automatic apply_glitches(input logic [`SW_W-1:0] code);
		logic [`SW_W-1:0] mask;
		repeat (4) begin
			rng_state = xorshift32(rng_state);
			mask = rng_state[3:0];
			if (mask == '0)
				mask = 4'h6;
			sw = code ^ mask;
			expect_quiet(1 + int'(rng_state[15:8]) % (`DEBOUNCE_LEN / 2));
			sw = code;
			expect_quiet(1 + int'(rng_state[23:16]) % (`DEBOUNCE_LEN / 2));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [`SW_W-1:0] next_code;
		logic [`SW_W-1:0] second_code;
		test_name = "reset";
		rng_state = xorshift32(32'h681a_7cbd);
		cur_code  = listed_codes[int'(rng_state[7:0]) % 6];
		sw        = cur_code;
		RSTBTN    = 1'b1;
		repeat (8) begin
			next_sample();
			check_all_low();
		end
		RSTBTN = 1'b0;
		repeat (`DEBOUNCE_LEN / 2) begin // Switches not yet accepted
			check_all_low();
			next_sample();
		end

		test_name = "power-up programming";
		capture_prog(cur_code, START_MAX);
		expect_quiet(QUIET_CYC); // Only one sequence

		test_name = "random modes";
		repeat (N_RAND) begin
			pick_code(cur_code, 1'b1, next_code);
			change_mode(next_code);
			measure_line(cur_code);
		end

		test_name = "vga frame";
		if (cur_code != 4'h0)
			change_mode(4'h0);
		check_vga_frame();

		test_name = "switch glitches";
		apply_glitches(cur_code);
		expect_quiet(QUIET_CYC);
		measure_line(cur_code); // Timing unchanged

		test_name = "held change";
		pick_code(cur_code, 1'b1, next_code);
		change_mode(next_code);
		measure_line(cur_code);

		test_name = "change during busy";
		pick_code(cur_code, 1'b1, next_code);
		pick_code(next_code, 1'b1, second_code);
		sw = next_code;
		while (busy !== 1'b1) next_sample();
		sw = second_code; // Moves while the first sequence runs
		capture_prog(next_code, START_MAX);
		capture_prog(second_code, START_MAX);
		cur_code = second_code;
		measure_line(cur_code);

		test_name = "unlisted code";
		pick_code(cur_code, 1'b0, next_code);
		change_mode(next_code); // Expect 248/167
		measure_line(cur_code); // and 720p lines

		$display("sim passed");
		$finish;
	end

endmodule

/* hdmi_mode_gen.f */
+incdir+hw
hw/video_mode_pkg.sv
hw/clkgen_pkg.sv
hw/switch_sync.sv
hw/mode_ctrl.sv
hw/video_timing.sv
hw/clkgen_prog.sv
hw/hdmi_mode_gen.sv
tb/tb_hdmi_mode_gen.sv

/* Makefile */
# Verilator build and run of the mode generator testbench

VERILATOR ?= verilator
TOP       ?= tb_hdmi_mode_gen
FILELIST  ?= hdmi_mode_gen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

SRCS := $(shell grep -v '^+' $(FILELIST)) hw/video_defs.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@grep -qx 'sim passed' $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
